/* egress_queue.sv */
`timescale 1ns/1ps
`include "router_consts.svh"

module egress_queue (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr,
    input  logic [`ROUTER_WORD_W-1:0] wdata,
    input  logic                      wlast,
    output logic                      full,
    output logic                      q_valid,
    output logic [`ROUTER_WORD_W-1:0] q_data,
    output logic                      q_last,
    input  logic                      q_ready
);
    localparam int DEPTH = `ROUTER_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`ROUTER_WORD_W-1:0] data_mem [DEPTH];
    logic                      last_mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [PTR_W:0]            count;
    logic                      rd;

    assign q_valid = (count != '0);
    assign q_data  = data_mem[rd_ptr];
    assign q_last  = last_mem[rd_ptr];
    assign rd      = q_valid && q_ready;

    // Word in flight from the classifier counts as stored
    assign full = (count == (PTR_W+1)'(DEPTH)) ||
                  (wr && count == (PTR_W+1)'(DEPTH - 1));

    always_ff @(posedge clk) begin
        if (wr) begin
            data_mem[wr_ptr] <= wdata;
            last_mem[wr_ptr] <= wlast;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr && count == (PTR_W+1)'(DEPTH)));

endmodule

/* ingress_classifier.sv */
`timescale 1ns/1ps
`include "router_consts.svh"

module ingress_classifier (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               in_tvalid,
    input  logic [`ROUTER_WORD_W-1:0]                          in_tdata,
    input  logic                                               in_tlast,
    output logic                                               in_tready,
    input  router_regs_pkg::route_entry_t [`ROUTER_ROUTES-1:0] route_table,
    input  logic                                               fwd_en,
    input  logic [`ROUTER_NUM_PORTS-1:0]                       q_full,
    output logic [`ROUTER_NUM_PORTS-1:0]                       q_wr,
    output logic [`ROUTER_WORD_W-1:0]                          q_wdata,
    output logic                                               q_wlast,
    output logic                                               drop_pulse
);
    import router_types_pkg::*;
    import router_regs_pkg::*;

    router_word_u in_word;
    route_entry_t hdr_route;
    logic         in_pkt;
    logic         drop_q;
    port_idx_t    port_q;
    logic         cur_drop;
    port_idx_t    cur_port;
    logic         in_hs;

    assign in_word   = router_word_u'(in_tdata);
    assign hdr_route = route_table[in_word.hdr.dest_addr];

    // Header picks the route, the rest of the packet follows it
    assign cur_drop = in_pkt ? drop_q : !hdr_route.valid;
    assign cur_port = in_pkt ? port_q : hdr_route.port;

    // Dropped words never wait on a queue
    assign in_tready = fwd_en && (cur_drop || !q_full[cur_port]);
    assign in_hs     = in_tvalid && in_tready;

    ////////////////////////////////////////
    // Packet state and queue writes

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt     <= 1'b0;
            drop_q     <= 1'b0;
            port_q     <= '0;
            q_wr       <= '0;
            drop_pulse <= 1'b0;
        end else begin
            q_wr       <= '0;
            drop_pulse <= 1'b0;
            if (in_hs) begin
                in_pkt <= !in_tlast;
                drop_q <= cur_drop;
                port_q <= cur_port;
                if (cur_drop) begin
                    drop_pulse <= in_tlast;
                end else begin
                    q_wr[cur_port] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_hs) begin
            q_wdata <= in_word.raw;
            q_wlast <= in_tlast;
        end
    end

    a_one_queue_write: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(q_wr));

endmodule

/* output_scheduler.sv */
`timescale 1ns/1ps
`include "router_consts.svh"

module output_scheduler (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic [`ROUTER_NUM_PORTS-1:0]                     q_valid,
    input  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_WORD_W-1:0] q_data,
    input  logic [`ROUTER_NUM_PORTS-1:0]                     q_last,
    output logic [`ROUTER_NUM_PORTS-1:0]                     q_ready,
    output logic                                             out_tvalid,
    output logic [`ROUTER_WORD_W-1:0]                        out_tdata,
    output logic                                             out_tlast,
    output router_types_pkg::port_idx_t                      out_tdest,
    input  logic                                             out_tready
);
    import router_types_pkg::*;

    localparam int N = `ROUTER_NUM_PORTS;

    logic      busy;
    port_idx_t grant_q;
    port_idx_t rr_ptr;
    port_idx_t pick;
    logic      pick_ok;
    port_idx_t sel;
    logic      out_hs;

    // First non-empty queue at or after the pointer
    always_comb begin
        port_idx_t idx;
        pick    = rr_ptr;
        pick_ok = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin
            idx = port_idx_t'((int'(rr_ptr) + i) % N);
            if (q_valid[idx]) begin
                pick    = idx;
                pick_ok = 1'b1;
            end
        end
    end

    assign sel        = busy ? grant_q : pick;
    assign out_tvalid = busy ? q_valid[grant_q] : pick_ok;
    assign out_tdata  = q_data[sel];
    assign out_tlast  = q_last[sel];
    assign out_tdest  = sel;
    assign out_hs     = out_tvalid && out_tready;

    always_comb begin
        q_ready      = '0;
        q_ready[sel] = out_hs;
    end

    ////////////////////////////////////////
    // Grant held from first shown word to tlast

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            grant_q <= '0;
            rr_ptr  <= '0;
        end else if (out_hs && out_tlast) begin
            busy   <= 1'b0;
            rr_ptr <= port_idx_t'((int'(sel) + 1) % N);
        end else if (!busy && pick_ok) begin
            busy    <= 1'b1;
            grant_q <= pick;
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata)
            && $stable(out_tlast) && $stable(out_tdest));

endmodule

/* project.f */
+incdir+.
router_types_pkg.sv
router_regs_pkg.sv
router_regs.sv
ingress_classifier.sv
egress_queue.sv
output_scheduler.sv
router_top.sv
tb_router.sv

/* router_consts.svh */
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// Egress queues, also the number of tdest values
`define ROUTER_NUM_PORTS    4

// Stream word width in bits
`define ROUTER_WORD_W       32

// Words per egress queue, power of two
`define ROUTER_QUEUE_DEPTH  8

// One route entry per destination address
`define ROUTER_ROUTES       16

// Register byte address width
`define ROUTER_AXIL_ADDR_W  8

`endif

/* router_regs.sv */
`timescale 1ns/1ps
`include "router_consts.svh"

module router_regs (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic [`ROUTER_AXIL_ADDR_W-1:0]                     awaddr,
    input  logic                                               awvalid,
    output logic                                               awready,
    input  logic [31:0]                                        wdata,
    input  logic [3:0]                                         wstrb,
    input  logic                                               wvalid,
    output logic                                               wready,
    output logic [1:0]                                         bresp,
    output logic                                               bvalid,
    input  logic                                               bready,
    input  logic [`ROUTER_AXIL_ADDR_W-1:0]                     araddr,
    input  logic                                               arvalid,
    output logic                                               arready,
    output logic [31:0]                                        rdata,
    output logic [1:0]                                         rresp,
    output logic                                               rvalid,
    input  logic                                               rready,
    input  logic                                               out_tvalid,
    input  logic                                               out_tready,
    input  logic                                               out_tlast,
    input  router_types_pkg::port_idx_t                        out_tdest,
    input  logic                                               drop_pulse,
    output router_regs_pkg::route_entry_t [`ROUTER_ROUTES-1:0] route_table,
    output logic                                               fwd_en
);
    import router_regs_pkg::*;

    logic                                 aw_got;
    logic                                 w_got;
    logic [`ROUTER_AXIL_ADDR_W-1:0]       aw_addr_q;
    logic [31:0]                          w_data_q;
    logic                                 w_lane0_q;
    logic                                 aw_hs;
    logic                                 w_hs;
    logic                                 wr_commit;
    logic [`ROUTER_AXIL_ADDR_W-1:0]       wr_addr;
    logic [31:0]                          wr_data;
    logic                                 wr_lane0;
    logic [`ROUTER_NUM_PORTS-1:0][31:0]   dlvr_cnt;
    logic [31:0]                          drop_cnt;
    logic [31:0]                          rd_word;

    function automatic logic [$clog2(`ROUTER_ROUTES)-1:0] route_slot(
        input logic [`ROUTER_AXIL_ADDR_W-1:0] addr);
        logic [`ROUTER_AXIL_ADDR_W-1:0] off;
        off = addr - REG_ROUTE_BASE;
        return off[2 +: $clog2(`ROUTER_ROUTES)];
    endfunction

    function automatic logic [$clog2(`ROUTER_NUM_PORTS)-1:0] dlvr_slot(
        input logic [`ROUTER_AXIL_ADDR_W-1:0] addr);
        logic [`ROUTER_AXIL_ADDR_W-1:0] off;
        off = addr - REG_DLVR_BASE;
        return off[2 +: $clog2(`ROUTER_NUM_PORTS)];
    endfunction

    ////////////////////////////////////////
    // Write channel

    assign awready = !bvalid && !aw_got;
    assign wready  = !bvalid && !w_got;
    assign bresp   = 2'b00;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;

    // Address and data may come in either order
    assign wr_commit = (aw_hs || aw_got) && (w_hs || w_got);
    assign wr_addr   = aw_got ? aw_addr_q : awaddr;
    assign wr_data   = w_got ? w_data_q : wdata;
    assign wr_lane0  = w_got ? w_lane0_q : wstrb[0];

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= awaddr;
        end
        if (w_hs) begin
            w_data_q  <= wdata;
            w_lane0_q <= wstrb[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b0;
        end else if (wr_commit) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b1;
        end else begin
            if (aw_hs) begin
                aw_got <= 1'b1;
            end
            if (w_hs) begin
                w_got <= 1'b1;
            end
            if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Only byte lane 0 holds writable bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            route_table <= '0;
            fwd_en      <= 1'b0;
        end else if (wr_commit && wr_lane0) begin
            if (wr_addr < REG_DLVR_BASE) begin
                route_table[route_slot(wr_addr)] <=
                    route_entry_t'(wr_data[$bits(route_entry_t)-1:0]);
            end else if (wr_addr == REG_CTRL) begin
                fwd_en <= wr_data[0];
            end
        end
    end

    ////////////////////////////////////////
    // Event counters

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dlvr_cnt <= '0;
            drop_cnt <= '0;
        end else begin
            if (out_tvalid && out_tready && out_tlast) begin
                dlvr_cnt[out_tdest] <= dlvr_cnt[out_tdest] + 1'b1;
            end
            if (drop_pulse) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Read channel

    assign arready = !rvalid;
    assign rresp   = 2'b00;

    always_comb begin
        rd_word = '0;
        if (araddr < REG_DLVR_BASE) begin
            rd_word = 32'(route_table[route_slot(araddr)]);
        end else if (araddr < REG_DROP) begin
            rd_word = dlvr_cnt[dlvr_slot(araddr)];
        end else if (araddr == REG_DROP) begin
            rd_word = drop_cnt;
        end else if (araddr == REG_CTRL) begin
            rd_word = {31'd0, fwd_en};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= rd_word;
        end
    end

    // A response only after both halves of a write were taken
    a_bvalid_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bvalid) |-> $past(aw_hs || aw_got) && $past(w_hs || w_got));

endmodule

/* router_regs_pkg.sv */
`include "router_consts.svh"

package router_regs_pkg;

    // Route table slot, bits 2:0 of its register
    typedef struct packed {
        logic                        valid;
        router_types_pkg::port_idx_t port;
    } route_entry_t;

    // Register map byte offsets
    localparam logic [`ROUTER_AXIL_ADDR_W-1:0] REG_ROUTE_BASE = 'h00;
    localparam logic [`ROUTER_AXIL_ADDR_W-1:0] REG_DLVR_BASE  = 'h40;
    localparam logic [`ROUTER_AXIL_ADDR_W-1:0] REG_DROP       = 'h50;
    localparam logic [`ROUTER_AXIL_ADDR_W-1:0] REG_CTRL       = 'h54;

endpackage

/* router_top.sv */
`timescale 1ns/1ps
`include "router_consts.svh"

module router_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [`ROUTER_AXIL_ADDR_W-1:0]    awaddr,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [31:0]                       wdata,
    input  logic [3:0]                        wstrb,
    input  logic                              wvalid,
    output logic                              wready,
    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  logic                              bready,
    input  logic [`ROUTER_AXIL_ADDR_W-1:0]    araddr,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [31:0]                       rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  logic                              rready,
    input  logic                              in_tvalid,
    output logic                              in_tready,
    input  logic [`ROUTER_WORD_W-1:0]         in_tdata,
    input  logic                              in_tlast,
    output logic                              out_tvalid,
    input  logic                              out_tready,
    output logic [`ROUTER_WORD_W-1:0]         out_tdata,
    output logic                              out_tlast,
    output router_types_pkg::port_idx_t       out_tdest
);
    import router_regs_pkg::*;

    localparam int N = `ROUTER_NUM_PORTS;

    route_entry_t [`ROUTER_ROUTES-1:0] route_table;
    logic                              fwd_en;
    logic                              drop_pulse;
    logic [N-1:0]                      q_full;
    logic [N-1:0]                      q_wr;
    logic [`ROUTER_WORD_W-1:0]         q_wdata;
    logic                              q_wlast;
    logic [N-1:0]                      q_valid;
    logic [N-1:0][`ROUTER_WORD_W-1:0]  q_data;
    logic [N-1:0]                      q_last;
    logic [N-1:0]                      q_ready;

    router_regs router_regs_inst (.*);

    ingress_classifier ingress_classifier_inst (.*);

    // One queue per egress port, all fed from the shared write bus
    for (genvar p = 0; p < N; p++) begin : g_queue
        egress_queue egress_queue_inst (
            .clk     ( clk        ),
            .rst_n   ( rst_n      ),
            .wr      ( q_wr[p]    ),
            .wdata   ( q_wdata    ),
            .wlast   ( q_wlast    ),
            .full    ( q_full[p]  ),
            .q_valid ( q_valid[p] ),
            .q_data  ( q_data[p]  ),
            .q_last  ( q_last[p]  ),
            .q_ready ( q_ready[p] )
        );
    end

    output_scheduler output_scheduler_inst (.*);

endmodule

/* router_trace.txt */
# W addr data | R addr expected | P dest len flow payload... | O tdest data last | D
# All fields hex, a header word is {dest_addr[3:0], len[7:0], flow_id[19:0]}
R 00 00000000
R 3c 00000000
R 40 00000000
R 4c 00000000
R 50 00000000
R 54 00000000
# Forwarding off, dest 1 goes to port 2
W 04 00000006
P 1 2 00abc 11111111 22222222
R 48 00000000
R 54 00000000
O 2 10200abc 0
O 2 11111111 0
O 2 22222222 1
W 54 00000001
D
R 48 00000001
# Burst over all ports, dest 5 has no route
W 08 00000004
W 0c 00000007
W 10 00000005
P 2 1 00001 a0000001
P 3 0 00002
P 4 2 00003 b0000001 b0000002
P 5 1 00005 dead0001
P 1 1 00004 c0000001
P 2 1 00008 a0000002
O 0 20100001 0
O 0 a0000001 1
O 3 30000002 1
O 1 40200003 0
O 1 b0000001 0
O 1 b0000002 1
O 2 10100004 0
O 2 c0000001 1
O 0 20100008 0
O 0 a0000002 1
D
# New mapping, dest 2 to port 3 and dest 1 off
W 08 00000007
W 04 00000000
P 2 0 00006
P 1 0 00007
O 3 20000006 1
D
R 40 00000002
R 44 00000001
R 48 00000002
R 4c 00000002
R 50 00000002
R 08 00000007
R 54 00000001

/* router_types_pkg.sv */
`include "router_consts.svh"

package router_types_pkg;

    // Egress port number, doubles as tdest
    typedef logic [$clog2(`ROUTER_NUM_PORTS)-1:0] port_idx_t;

    // First word of every packet
    typedef struct packed {
        logic [$clog2(`ROUTER_ROUTES)-1:0] dest_addr;
        logic [7:0]                        len;      // payload words, zero for header only
        logic [19:0]                       flow_id;
    } router_hdr_t;

    // Same stream word, read as header or as payload
    typedef union packed {
        router_hdr_t               hdr;
        logic [`ROUTER_WORD_W-1:0] raw;
    } router_word_u;

endpackage

/* run.sh */
#!/bin/sh
# Build the router testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_router \
    -f project.f -o sim_router \
    && ./obj_dir/sim_router | tee /dev/stderr | grep -q "Regression passed" \
    && echo "Run OK" \
    || { echo "Run FAILED"; exit 1; }

/* tb_router.sv */
`timescale 1ns/1ps
`include "router_consts.svh"

module tb_router;

    localparam int N               = `ROUTER_NUM_PORTS;
    localparam int CYCLES_PER_LINE = 200;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic [`ROUTER_AXIL_ADDR_W-1:0]  awaddr;
    logic                            awvalid;
    logic                            awready;
    logic [31:0]                     wdata;
    logic [3:0]                      wstrb;
    logic                            wvalid;
    logic                            wready;
    logic [1:0]                      bresp;
    logic                            bvalid;
    logic                            bready;
    logic [`ROUTER_AXIL_ADDR_W-1:0]  araddr;
    logic                            arvalid;
    logic                            arready;
    logic [31:0]                     rdata;
    logic [1:0]                      rresp;
    logic                            rvalid;
    logic                            rready;
    logic                            in_tvalid;
    logic                            in_tready;
    logic [`ROUTER_WORD_W-1:0]       in_tdata;
    logic                            in_tlast;
    logic                            out_tvalid;
    logic                            out_tready;
    logic [`ROUTER_WORD_W-1:0]       out_tdata;
    logic                            out_tlast;
    router_types_pkg::port_idx_t     out_tdest;

    // Words waiting to enter, and expected words per tdest, each {last, data}
    logic [32:0] in_words [$];
    logic [32:0] exp_q [N][$];
    logic        fwd_on      = 1'b0;
    int          trace_lines = 0;
    int          reg_errors  = 0;
    int          out_errors  = 0;

    router_top router_top_inst (.*);

    always #5 clk = ~clk;

    function automatic int pending_words();
        int total;
        total = 0;
        for (int p = 0; p < N; p++) begin
            total += exp_q[p].size();
        end
        return total;
    endfunction

    ////////////////////////////////////////
    // Register bus

    task automatic axil_write(input logic [`ROUTER_AXIL_ADDR_W-1:0] addr,
                              input logic [31:0] data);
        logic aw_done;
        logic w_done;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hf;
        wvalid  = 1'b1;
        while (awvalid || wvalid) begin
            @(negedge clk);
            aw_done = awvalid && awready;
            w_done  = wvalid && wready;
            @(posedge clk);
            #1;
            if (aw_done) begin
                awvalid = 1'b0;
            end
            if (w_done) begin
                wvalid = 1'b0;
            end
        end
        // Mirror of the forwarding enable for the ingress check
        if (addr == 'h54) begin
            fwd_on = data[0];
        end
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        assert (bresp == 2'b00) else begin
            $display("error %0t: write of 0x%02h gave response %b, expected OKAY",
                     $time, addr, bresp);
            reg_errors++;
        end
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read_check(input logic [`ROUTER_AXIL_ADDR_W-1:0] addr,
                                   input logic [31:0] expect_val);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        assert (rdata == expect_val) else begin
            $display("error %0t: read of 0x%02h gave %h, expected %h",
                     $time, addr, rdata, expect_val);
            reg_errors++;
        end
        assert (rresp == 2'b00) else begin
            $display("error %0t: read of 0x%02h gave response %b, expected OKAY",
                     $time, addr, rresp);
            reg_errors++;
        end
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // Idle means nothing left to send or expect, and a quiet output for a while
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 8) begin
            @(negedge clk);
            if (in_words.size() == 0 && !in_tvalid && !out_tvalid && pending_words() == 0) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////
    // Stream drivers and output checker

    initial begin : ingress_driver
        logic accept;
        in_tvalid = 1'b0;
        in_tdata  = '0;
        in_tlast  = 1'b0;
        forever begin
            @(negedge clk);
            accept = in_tvalid && in_tready;
            assert (!accept || fwd_on) else begin
                $display("Ingress word %h was taken at %0t while forwarding was off",
                         in_tdata, $time);
                out_errors++;
            end
            @(posedge clk);
            #1;
            if (accept) begin
                in_tvalid = 1'b0;
            end
            if (!in_tvalid && in_words.size() != 0) begin
                {in_tlast, in_tdata} = in_words.pop_front();
                in_tvalid = 1'b1;
            end
        end
    end

    // Random stalls on the output, about one cycle in four
    initial begin : ready_driver
        out_tready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_tready = ($urandom % 4) != 0;
        end
    end

    always @(negedge clk) begin : output_monitor
        logic [32:0] want;
        if (rst_n && out_tvalid && out_tready) begin
            assert (exp_q[out_tdest].size() != 0) else begin
                $display("Extra output word %h on tdest %0d at %0t, none was expected",
                         out_tdata, out_tdest, $time);
                out_errors++;
            end
            if (exp_q[out_tdest].size() != 0) begin
                want = exp_q[out_tdest].pop_front();
                assert ({out_tlast, out_tdata} == want) else begin
                    $display("error %0t: tdest %0d gave %h last %b, expected %h last %b",
                             $time, out_tdest, out_tdata, out_tlast, want[31:0], want[32]);
                    out_errors++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Trace runner

    initial begin : trace_runner
        int                             fd;
        logic [8*256-1:0]               line;
        logic [63:0]                    tok;
        logic [`ROUTER_AXIL_ADDR_W-1:0] addr;
        logic [31:0]                    data;
        logic [3:0]                     dest;
        logic [7:0]                     len;
        logic [19:0]                    flow;
        logic [1:0]                     port;
        logic                           last;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        void'($urandom(2));
        fd = $fopen("router_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open router_trace.txt");
            $display("Regression failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    trace_lines++;
                end
            end
            $fclose(fd);
            fd = $fopen("router_trace.txt", "r");
            repeat (10) @(posedge clk);
            #1;
            rst_n = 1'b1;
            repeat (2) @(posedge clk);
            #1;
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    void'($fgets(line, fd));
                end else if (tok == "W") begin
                    void'($fscanf(fd, "%h %h", addr, data));
                    axil_write(addr, data);
                end else if (tok == "R") begin
                    void'($fscanf(fd, "%h %h", addr, data));
                    axil_read_check(addr, data);
                end else if (tok == "P") begin
                    void'($fscanf(fd, "%h %h %h", dest, len, flow));
                    in_words.push_back({len == 8'd0, dest, len, flow});
                    for (int i = 0; i < int'(len); i++) begin
                        void'($fscanf(fd, "%h", data));
                        in_words.push_back({i == int'(len) - 1, data});
                    end
                end else if (tok == "O") begin
                    void'($fscanf(fd, "%h %h %h", port, data, last));
                    exp_q[port].push_back({last, data});
                end else if (tok == "D") begin
                    wait_idle();
                end else begin
                    $display("Unknown line type in router_trace.txt");
                    reg_errors++;
                end
            end
            $fclose(fd);
            repeat (20) @(posedge clk);
            for (int p = 0; p < N; p++) begin
                assert (exp_q[p].size() == 0) else begin
                    $display("%0d expected words never came out on tdest %0d",
                             exp_q[p].size(), p);
                    reg_errors++;
                end
            end
            $display("Errors: %0d register or trace, %0d stream", reg_errors, out_errors);
            if (reg_errors == 0 && out_errors == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (trace_lines != 0);
        repeat (CYCLES_PER_LINE * trace_lines) @(posedge clk);
        $display("Timeout, %0d expected output words and %0d ingress words still pending",
                 pending_words(), in_words.size());
        $display("Regression failed");
        $finish;
    end

endmodule
